/* project.f */
fire_pkg.sv
lane_result_if.sv
pixel_ingress.sv
expand_bank.sv
channel_concat.sv
fire_expand.sv
fire_expand_props.sv
tb_fire_expand.sv

/* Bender.yml */
package:
  name: fire_expand

sources:
  - fire_pkg.sv
  - lane_result_if.sv
  - pixel_ingress.sv
  - expand_bank.sv
  - channel_concat.sv
  - fire_expand.sv
  - target: test
    files:
      - fire_expand_props.sv
      - tb_fire_expand.sv

/* tb_fire_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fire_expand;

	localparam int CHIN = fire_pkg::CHIN_DEFAULT;
	localparam int LANES = fire_pkg::LANES_DEFAULT;
	localparam int WORDS = 2 * LANES;
	localparam int CW = $clog2(WORDS);
	// 1 + 2 + 20 + 12 pixels over the four phases
	localparam int PIXELS = 35;
	// Longest random wait per handshake edge
	localparam int MAX_DELAY = 15;
	localparam int WATCHDOG_CYCLES = PIXELS * (CHIN + WORDS) * (MAX_DELAY + 1) * 4 + 2000;

	logic clk;
	logic rst_n;
	logic pix_req;
	logic pix_ack;
	fire_pkg::act_t pix_data;
	logic out_req;
	logic out_ack;
	fire_pkg::act_t out_data;
	logic [CW-1:0] out_chan;

	// Separate LFSR states for input and output sides
	logic [31:0] stim_lfsr;
	logic [31:0] ack_lfsr;
	fire_pkg::act_t pixel_acts [CHIN];
	fire_pkg::act_t exp_data_q [$];
	logic [CW-1:0] exp_chan_q [$];
	int req_delay_max;
	int ack_delay_max;
	int stall_run;
	int max_stall;
	logic saw_zero;
	logic saw_sat;

	fire_expand #(
		.CHIN(CHIN),
		.LANES(LANES)
	) fire_expand_i (
		.clk(clk),
		.rst_n(rst_n),
		.pix_req(pix_req),
		.pix_ack(pix_ack),
		.pix_data(pix_data),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_chan(out_chan)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and compare tasks
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic take_bits(inout logic [31:0] st, input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(st[31]);
			st = lfsr_next(st);
		end
	endtask

	task automatic random_wait(inout logic [31:0] st, input int max_d);
		int v;
		if (max_d > 0) begin
			take_bits(st, 4, v);
			repeat (v % (max_d + 1)) @(negedge clk);
		end
	endtask

	task automatic check_act(input string name, input fire_pkg::act_t got,
			input fire_pkg::act_t exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_chan(input string name, input logic [CW-1:0] got,
			input logic [CW-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model and input driver
	//////////////////////////////////////////////////////////////////////

	// MAC over all channels plus bias and requant with bank 0 lanes first
	task automatic model_pixel();
		fire_pkg::acc_t sum;
		fire_pkg::acc_t scaled;
		fire_pkg::act_t r;
		for (int b = 0; b < 2; b++) begin
			for (int l = 0; l < LANES; l++) begin
				sum = fire_pkg::bias_of(b, l);
				for (int c = 0; c < CHIN; c++) begin
					sum = sum + fire_pkg::acc_t'(int'(pixel_acts[c]) *
						int'(fire_pkg::weight_of(b, l, c)));
				end
				// ReLU then scale down and clamp to 8 bits
				if (sum < 0) begin
					r = 8'h00;
				end else begin
					scaled = sum / (1 << fire_pkg::OUT_SHIFT);
					r = (scaled > 255) ? 8'hff : fire_pkg::act_t'(scaled);
				end
				exp_data_q.push_back(r);
				exp_chan_q.push_back(CW'(b * LANES + l));
			end
		end
	endtask

	// Full four-phase cycle on the activation link
	task automatic send_word(input fire_pkg::act_t d);
		random_wait(stim_lfsr, req_delay_max);
		pix_data = d;
		pix_req = 1'b1;
		@(negedge clk);
		while (!pix_ack) @(negedge clk);
		pix_req = 1'b0;
		@(negedge clk);
		while (pix_ack) @(negedge clk);
	endtask

	task automatic run_pixel();
		model_pixel();
		for (int c = 0; c < CHIN; c++) begin
			send_word(pixel_acts[c]);
		end
	endtask

	task automatic fill_random();
		int v;
		for (int c = 0; c < CHIN; c++) begin
			take_bits(stim_lfsr, 8, v);
			pixel_acts[c] = fire_pkg::act_t'(v);
		end
	endtask

	task automatic drain();
		while (exp_data_q.size() != 0) @(negedge clk);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output responder and monitors
	//////////////////////////////////////////////////////////////////////

	// Check each word, then ack with random delays
	initial begin
		forever begin
			@(negedge clk);
			if (out_req) begin
				random_wait(ack_lfsr, ack_delay_max);
				if (exp_data_q.size() == 0) begin
					report_failure("Output word arrived with nothing expected");
				end
				check_chan("out_chan", out_chan, exp_chan_q.pop_front());
				check_act("out_data", out_data, exp_data_q.pop_front());
				// Extremes actually seen on the output
				saw_zero = saw_zero | (out_data == 8'h00);
				saw_sat = saw_sat | (out_data == 8'hff);
				out_ack = 1'b1;
				while (out_req) @(negedge clk);
				random_wait(ack_lfsr, ack_delay_max);
				out_ack = 1'b0;
			end
		end
	end

	// Longest run of a request left waiting on pix_ack
	always @(negedge clk) begin
		if (rst_n && pix_req && !pix_ack) begin
			stall_run = stall_run + 1;
			if (stall_run > max_stall) begin
				max_stall = stall_run;
			end
		end else begin
			stall_run = 0;
		end
	end

	always @(negedge clk) begin
		if (fire_expand_i.props_i.fail_count != 0) begin
			report_failure("A handshake assertion fired");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure("Run timed out waiting on the DUT");
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		pix_req = 1'b0;
		pix_data = '0;
		out_ack = 1'b0;
		stim_lfsr = 32'hf509_4349;
		ack_lfsr = 32'hf509_4349;
		req_delay_max = 0;
		ack_delay_max = 0;
		stall_run = 0;
		max_stall = 0;
		saw_zero = 1'b0;
		saw_sat = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Both links quiet out of reset
		check_flag("pix_ack", pix_ack, 1'b0);
		check_flag("out_req", out_req, 1'b0);
		// Single random pixel
		fill_random();
		run_pixel();
		drain();
		// Bank 1 lane 0 driven high and bank 0 lane 0 driven negative
		saw_zero = 1'b0;
		saw_sat = 1'b0;
		for (int c = 0; c < CHIN; c++) begin
			pixel_acts[c] = (fire_pkg::weight_of(1, 0, c) > 0) ? 8'hff : 8'h00;
		end
		run_pixel();
		for (int c = 0; c < CHIN; c++) begin
			pixel_acts[c] = (fire_pkg::weight_of(0, 0, c) < 0) ? 8'hff : 8'h00;
		end
		run_pixel();
		drain();
		if (!(saw_zero && saw_sat)) begin
			report_failure("Extreme pixels did not reach both zero and 255");
		end
		// Back-to-back pixels with random request delays
		req_delay_max = 7;
		ack_delay_max = 2;
		repeat (20) begin
			fill_random();
			run_pixel();
		end
		drain();
		// Slow consumer stalls the input
		req_delay_max = 1;
		ack_delay_max = MAX_DELAY;
		max_stall = 0;
		repeat (12) begin
			fill_random();
			run_pixel();
		end
		drain();
		if (max_stall < 8) begin
			report_failure("pix_ack never stalled under output back-pressure");
		end
		// Let the last handshake close, then watch for a stray word
		while (out_ack) @(negedge clk);
		repeat (4) @(negedge clk);
		if (out_req) begin
			report_failure("Output word offered after the last expected one");
		end else if (fire_expand_i.props_i.fail_count != 0) begin
			report_failure("A handshake assertion fired");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* fire_expand_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fire_expand_props (
	input wire clk,
	input wire rst_n,
	input wire pix_req,
	input wire pix_ack,
	input wire out_req,
	input wire out_ack,
	input wire fire_pkg::act_t out_data,
	input wire act_valid,
	input wire bank0_ready,
	input wire bank1_ready
);

	// Count of fired assertions, watched by the testbench
	int fail_count = 0;

	// pix_ack follows the request seen one cycle earlier
	pix_ack_order: assert property (@(posedge clk) disable iff (!rst_n)
		(pix_ack != $past(pix_ack)) |-> (pix_ack == $past(pix_req)))
		else begin
			fail_count = fail_count + 1;
			$error("pix_ack changed without matching pix_req edge");
		end

	// out_req moves only against the acknowledge
	out_req_order: assert property (@(posedge clk) disable iff (!rst_n)
		(out_req != $past(out_req)) |-> (out_req != $past(out_ack)))
		else begin
			fail_count = fail_count + 1;
			$error("out_req changed without matching out_ack edge");
		end

	// Word held for the whole request
	out_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(out_req && $past(out_req)) |-> $stable(out_data))
		else begin
			fail_count = fail_count + 1;
			$error("out_data changed while out_req high");
		end

	// Broadcast only into banks that can take it
	strobe_ready: assert property (@(posedge clk) disable iff (!rst_n)
		act_valid |-> (bank0_ready && bank1_ready))
		else begin
			fail_count = fail_count + 1;
			$error("act_valid while a bank was not ready");
		end

endmodule

bind fire_expand fire_expand_props props_i (
	.clk(clk),
	.rst_n(rst_n),
	.pix_req(pix_req),
	.pix_ack(pix_ack),
	.out_req(out_req),
	.out_ack(out_ack),
	.out_data(out_data),
	.act_valid(act_valid),
	.bank0_ready(bank0_ready),
	.bank1_ready(bank1_ready)
);

`default_nettype wire

/* fire_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module fire_expand #(
	parameter int CHIN = fire_pkg::CHIN_DEFAULT,
	parameter int LANES = fire_pkg::LANES_DEFAULT
) (
	input wire clk,
	input wire rst_n,
	input wire pix_req,
	output logic pix_ack,
	input wire fire_pkg::act_t pix_data,
	output logic out_req,
	input wire out_ack,
	output fire_pkg::act_t out_data,
	output logic [$clog2(2*LANES)-1:0] out_chan
);

	//////////////////////////////////////////////////////////////////////
	// Activation broadcast
	//////////////////////////////////////////////////////////////////////

	logic act_valid;
	fire_pkg::act_t act_data;
	logic bank0_ready;
	logic bank1_ready;

	lane_result_if #(.LANES(LANES)) res0_if ();
	lane_result_if #(.LANES(LANES)) res1_if ();

	pixel_ingress pixel_ingress_i (
		.clk(clk),
		.rst_n(rst_n),
		.pix_req(pix_req),
		.pix_ack(pix_ack),
		.pix_data(pix_data),
		.bank0_ready(bank0_ready),
		.bank1_ready(bank1_ready),
		.act_valid(act_valid),
		.act_data(act_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Expand banks
	//////////////////////////////////////////////////////////////////////

	expand_bank #(
		.CHIN(CHIN),
		.LANES(LANES),
		.BANK_ID(0)
	) expand_bank0_i (
		.clk(clk),
		.rst_n(rst_n),
		.act_valid(act_valid),
		.act_data(act_data),
		.ready(bank0_ready),
		.res(res0_if.bank)
	);

	expand_bank #(
		.CHIN(CHIN),
		.LANES(LANES),
		.BANK_ID(1)
	) expand_bank1_i (
		.clk(clk),
		.rst_n(rst_n),
		.act_valid(act_valid),
		.act_data(act_data),
		.ready(bank1_ready),
		.res(res1_if.bank)
	);

	// Bank 0 channels go out first
	channel_concat #(
		.LANES(LANES)
	) channel_concat_i (
		.clk(clk),
		.rst_n(rst_n),
		.res0(res0_if.concat),
		.res1(res1_if.concat),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_chan(out_chan)
	);

endmodule

`default_nettype wire

/* channel_concat.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_concat #(
	parameter int LANES = 4
) (
	input wire clk,
	input wire rst_n,
	lane_result_if.concat res0,
	lane_result_if.concat res1,
	output logic out_req,
	input wire out_ack,
	output fire_pkg::act_t out_data,
	output logic [$clog2(2*LANES)-1:0] out_chan
);

	localparam int WORDS = 2 * LANES;
	localparam int IW = $clog2(WORDS);

	typedef enum logic [1:0] {
		OS_IDLE,
		OS_REQ,
		OS_REL
	} ostate_t;

	ostate_t ostate;
	logic [IW-1:0] word_idx;
	logic capture;
	logic ack0;
	logic ack1;

	// Bank 0 lanes low, bank 1 lanes high
	fire_pkg::act_t word_buf [WORDS];

	//////////////////////////////////////////////////////////////////////
	// Input side, both banks taken in one capture
	//////////////////////////////////////////////////////////////////////

	// Buffer is empty only while idle
	assign capture = (ostate == OS_IDLE) && res0.pending_ack && res1.pending_ack;

	assign res0.ack = ack0;
	assign res1.ack = ack1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack0 <= 1'b0;
			ack1 <= 1'b0;
		end else begin
			if (capture) begin
				ack0 <= 1'b1;
				ack1 <= 1'b1;
			end else begin
				// Each ack released on its own req
				if (ack0 && !res0.req) begin
					ack0 <= 1'b0;
				end
				if (ack1 && !res1.req) begin
					ack1 <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			for (int l = 0; l < LANES; l++) begin
				word_buf[l] <= res0.acts[l];
				word_buf[LANES + l] <= res1.acts[l];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output side, one word per four-phase cycle
	//////////////////////////////////////////////////////////////////////

	assign out_req = (ostate == OS_REQ);
	assign out_data = word_buf[word_idx];
	assign out_chan = word_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ostate <= OS_IDLE;
			word_idx <= '0;
		end else begin
			case (ostate)
				OS_IDLE: begin
					if (capture) begin
						word_idx <= '0;
						ostate <= OS_REQ;
					end
				end
				OS_REQ: begin
					if (out_ack) begin
						ostate <= OS_REL;
					end
				end
				OS_REL: begin
					if (!out_ack) begin
						// Last word done, buffer free again
						if (word_idx == IW'(WORDS - 1)) begin
							ostate <= OS_IDLE;
						end else begin
							word_idx <= word_idx + 1'b1;
							ostate <= OS_REQ;
						end
					end
				end
				default: ostate <= OS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* expand_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module expand_bank #(
	parameter int CHIN = 8,
	parameter int LANES = 4,
	parameter int BANK_ID = 0
) (
	input wire clk,
	input wire rst_n,
	input wire act_valid,
	input wire fire_pkg::act_t act_data,
	output logic ready,
	lane_result_if.bank res
);

	localparam int CW = (CHIN > 1) ? $clog2(CHIN) : 1;

	typedef enum logic [1:0] {
		ST_ACC,
		ST_FIN,
		ST_REQ,
		ST_REL
	} state_t;

	state_t state;
	logic [CW-1:0] chan_cnt;

	fire_pkg::acc_t acc [LANES];
	fire_pkg::acc_t prod [LANES];
	fire_pkg::acc_t biased [LANES];
	fire_pkg::weight_t wgt [LANES];
	fire_pkg::act_t acts_q [LANES];

	//////////////////////////////////////////////////////////////////////
	// Weight lookup and products
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			wgt[l] = fire_pkg::weight_of(BANK_ID, l, int'(chan_cnt));
			// Activation is unsigned, so zero extend before signed multiply
			prod[l] = $signed({1'b0, act_data}) * wgt[l];
			biased[l] = acc[l] + fire_pkg::bias_of(BANK_ID, l);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control and accumulators
	//////////////////////////////////////////////////////////////////////

	// Stall activations from last channel until ack falls
	assign ready = (state == ST_ACC);
	assign res.req = (state == ST_REQ);
	assign res.acts = acts_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_ACC;
			chan_cnt <= '0;
			for (int l = 0; l < LANES; l++) begin
				acc[l] <= '0;
			end
		end else begin
			case (state)
				ST_ACC: begin
					if (act_valid) begin
						for (int l = 0; l < LANES; l++) begin
							acc[l] <= acc[l] + prod[l];
						end
						// Last channel of the pixel
						if (chan_cnt == CW'(CHIN - 1)) begin
							chan_cnt <= '0;
							state <= ST_FIN;
						end else begin
							chan_cnt <= chan_cnt + 1'b1;
						end
					end
				end
				ST_FIN: begin
					// Clear for next pixel
					for (int l = 0; l < LANES; l++) begin
						acc[l] <= '0;
					end
					state <= ST_REQ;
				end
				ST_REQ: begin
					if (res.ack) begin
						state <= ST_REL;
					end
				end
				ST_REL: begin
					// Wait for concatenator to drop ack
					if (!res.ack) begin
						state <= ST_ACC;
					end
				end
				default: state <= ST_ACC;
			endcase
		end
	end

	// Bias, ReLU, shift, clamp; held until the next pixel finishes
	always_ff @(posedge clk) begin
		if (state == ST_FIN) begin
			for (int l = 0; l < LANES; l++) begin
				acts_q[l] <= fire_pkg::requant(biased[l]);
			end
		end
	end

endmodule

`default_nettype wire

/* pixel_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_ingress (
	input wire clk,
	input wire rst_n,
	input wire pix_req,
	output logic pix_ack,
	input wire fire_pkg::act_t pix_data,
	input wire bank0_ready,
	input wire bank1_ready,
	output logic act_valid,
	output fire_pkg::act_t act_data
);

	//////////////////////////////////////////////////////////////////////
	// Four-phase responder
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		ST_IDLE,
		ST_ACK
	} state_t;

	state_t state;
	logic accept;

	// Take a word only when both banks can use it
	assign accept = (state == ST_IDLE) && pix_req && bank0_ready && bank1_ready;

	assign pix_ack = (state == ST_ACK);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			act_valid <= 1'b0;
		end else begin
			// Strobe lasts one cycle
			act_valid <= accept;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					// Release once source drops req
					if (!pix_req) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Activation captured on the accept edge
	always_ff @(posedge clk) begin
		if (accept) begin
			act_data <= pix_data;
		end
	end

endmodule

`default_nettype wire

/* lane_result_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lane_result_if #(
	parameter int LANES = 4
) ();

	// Four-phase request from the bank
	logic req;
	// Acknowledge from the concatenator
	logic ack;
	// Finished lane results, stable while req is high
	fire_pkg::act_t acts [LANES];
	// Request raised but not yet taken
	logic pending_ack;

	assign pending_ack = req && !ack;

	modport bank (
		output req,
		output acts,
		input ack
	);

	modport concat (
		input req,
		input acts,
		input pending_ack,
		output ack
	);

endinterface

`default_nettype wire

/* fire_pkg.sv */
`default_nettype none

package fire_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	localparam int ACT_W = 8;
	localparam int WGT_W = 8;
	// Wide enough for CHIN * 255 * max weight plus bias
	localparam int ACC_W = 24;

	// Input channels per pixel
	localparam int CHIN_DEFAULT = 8;
	// Filters per expand bank
	localparam int LANES_DEFAULT = 4;
	// Requantization shift before 8 bit clamp
	localparam int OUT_SHIFT = 6;

	typedef logic [ACT_W-1:0] act_t;
	typedef logic signed [WGT_W-1:0] weight_t;
	// Also used for biases
	typedef logic signed [ACC_W-1:0] acc_t;

	//////////////////////////////////////////////////////////////////////
	// Weight ROM and bias memory contents
	//////////////////////////////////////////////////////////////////////

	// Fixed mix of bank, lane and channel, range -30 .. 30
	function automatic weight_t weight_of(int bank, int lane, int chan);
		int mix;
		mix = bank * 37 + lane * 13 + chan * 11 + lane * chan * 5;
		return weight_t'((mix % 61) - 30);
	endfunction

	// Per lane bias, multiples of 64 in -256 .. 256
	function automatic acc_t bias_of(int bank, int lane);
		int mix;
		mix = (bank * 7 + lane * 5) % 9;
		return acc_t'((mix - 4) * 64);
	endfunction

	// ReLU, shift down, clamp to 255
	function automatic act_t requant(acc_t v);
		acc_t shifted;
		if (v < 0) begin
			return '0;
		end
		shifted = v >>> OUT_SHIFT;
		if (shifted > acc_t'(255)) begin
			return act_t'(255);
		end
		// Fits in 8 bits here
		return act_t'(shifted);
	endfunction

endpackage

`default_nettype wire
